// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP   = tb_eth_ipg_phy
FLIST = list.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: eth_ipg_phy.sv
// PHY with inter-frame side channel
`timescale 1ns/100ps

module eth_ipg_phy (
  input  logic                   tx_clk,
  input  logic                   rst,
  input  phy_pkg::xgmii_word_t   xgmii_tx,
  output phy_pkg::xgmii_word_t   xgmii_rx,
  output phy_pkg::serdes_block_t serdes_tx,
  input  phy_pkg::serdes_block_t serdes_rx,
  input  phy_pkg::ipg_req_t      ipg_req,
  output logic                   ipg_ack,
  output phy_pkg::ipg_chunk_t    ipg_chunk,
  output logic                   ipg_valid,
  output logic                   rx_bad_block,
  output logic                   rx_block_lock
);
  import phy_pkg::*;

  logic       pop;
  logic       head_valid;
  ipg_chunk_t head_chunk;

  ipg_req_queue i_ipg_req_queue (
    .tx_clk     (tx_clk),
    .rst        (rst),
    .ipg_req    (ipg_req),
    .ipg_ack    (ipg_ack),
    .pop        (pop),
    .head_valid (head_valid),
    .head_chunk (head_chunk)
  );

  ipg_tx_encoder i_ipg_tx_encoder (
    .tx_clk     (tx_clk),
    .rst        (rst),
    .xgmii_tx   (xgmii_tx),
    .head_valid (head_valid),
    .head_chunk (head_chunk),
    .pop        (pop),
    .serdes_tx  (serdes_tx)
  );

  // Receive side shares tx_clk
  ipg_rx_decoder i_ipg_rx_decoder (
    .tx_clk        (tx_clk),
    .rst           (rst),
    .serdes_rx     (serdes_rx),
    .xgmii_rx      (xgmii_rx),
    .ipg_chunk     (ipg_chunk),
    .ipg_valid     (ipg_valid),
    .rx_bad_block  (rx_bad_block),
    .rx_block_lock (rx_block_lock)
  );

endmodule

// File: eth_ipg_phy_assert.sv
// PHY protocol assertions
`timescale 1ns/100ps

module eth_ipg_phy_assert (
  input logic                   tx_clk,
  input logic                   rst,
  input phy_pkg::ipg_req_t      ipg_req,
  input logic                   ipg_ack,
  input logic                   ipg_valid,
  input phy_pkg::serdes_block_t serdes_rx,
  input logic                   rx_bad_block,
  input logic                   rx_block_lock
);
  import phy_pkg::*;

  int   fail_count = 0;
  logic hdr_ok;
  logic blk_ok;

  assign hdr_ok = (serdes_rx.hdr == SYNC_DATA) || (serdes_rx.hdr == SYNC_CTRL);
  // Blocks that decode without an error word
  assign blk_ok = (serdes_rx.hdr == SYNC_DATA) ||
                  ((serdes_rx.hdr == SYNC_CTRL) &&
                   ((serdes_rx.payload.ctrl.block_type == BT_IDLE) ||
                    (serdes_rx.payload.ctrl.block_type == BT_IPG)));

  reset_values: assert property (@(posedge tx_clk)
    rst |=> (!ipg_ack && !ipg_valid && !rx_bad_block && !rx_block_lock)) else begin
    $error("Status outputs not low after a reset cycle");
    fail_count++;
  end

  ack_rise: assert property (@(posedge tx_clk) disable iff (rst)
    $rose(ipg_ack) |-> $past(ipg_req.req)) else begin
    $error("ipg_ack rose without a pending request");
    fail_count++;
  end

  ack_fall: assert property (@(posedge tx_clk) disable iff (rst)
    $fell(ipg_ack) |-> !$past(ipg_req.req)) else begin
    $error("ipg_ack fell while the request was still high");
    fail_count++;
  end

  bad_block_cause: assert property (@(posedge tx_clk) disable iff (rst)
    rx_bad_block |-> $past(!blk_ok)) else begin
    $error("rx_bad_block pulsed without an invalid block");
    fail_count++;
  end

  lock_drop: assert property (@(posedge tx_clk) disable iff (rst)
    !hdr_ok |=> !rx_block_lock) else begin
    $error("rx_block_lock stayed high after an invalid header");
    fail_count++;
  end

endmodule

bind eth_ipg_phy eth_ipg_phy_assert i_eth_ipg_phy_assert (
  .tx_clk        (tx_clk),
  .rst           (rst),
  .ipg_req       (ipg_req),
  .ipg_ack       (ipg_ack),
  .ipg_valid     (ipg_valid),
  .serdes_rx     (serdes_rx),
  .rx_bad_block  (rx_bad_block),
  .rx_block_lock (rx_block_lock)
);

// File: ipg_req_queue.sv
// Side-channel request queue
`timescale 1ns/100ps

module ipg_req_queue (
  input  logic                tx_clk,
  input  logic                rst,
  input  phy_pkg::ipg_req_t   ipg_req,
  output logic                ipg_ack,
  input  logic                pop,
  output logic                head_valid,
  output phy_pkg::ipg_chunk_t head_chunk
);
  import phy_pkg::*;

  ipg_chunk_t mem [2];
  logic [1:0] count;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       slot_free;
  logic       push;
  logic       do_pop;

  // A slot popped this cycle can take the new chunk
  assign do_pop    = pop && head_valid;
  assign slot_free = (count != 2'd2) || do_pop;

  // New request only while ack is still low
  assign push = ipg_req.req && !ipg_ack && slot_free;

  assign head_valid = (count != 2'd0);
  assign head_chunk = mem[rd_ptr];

  always_ff @(posedge tx_clk) begin
    if (push) begin
      mem[wr_ptr] <= ipg_req.chunk;
    end
  end

  always_ff @(posedge tx_clk) begin
    if (rst) begin
      count   <= 2'd0;
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      ipg_ack <= 1'b0;
    end else begin
      // Four-phase ack
      if (push) begin
        ipg_ack <= 1'b1;
      end else if (!ipg_req.req) begin
        ipg_ack <= 1'b0;
      end

      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (do_pop) begin
        rd_ptr <= ~rd_ptr;
      end

      case ({push, do_pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: ipg_rx_decoder.sv
// 64b/66b receive decoder with block lock
`timescale 1ns/100ps

module ipg_rx_decoder (
  input  logic                   tx_clk,
  input  logic                   rst,
  input  phy_pkg::serdes_block_t serdes_rx,
  output phy_pkg::xgmii_word_t   xgmii_rx,
  output phy_pkg::ipg_chunk_t    ipg_chunk,
  output logic                   ipg_valid,
  output logic                   rx_bad_block,
  output logic                   rx_block_lock
);
  import phy_pkg::*;

  logic                  hdr_valid;
  logic                  bad_next;
  logic                  ipg_next;
  xgmii_word_t           word_next;
  xgmii_word_t           word_idle;
  xgmii_word_t           word_error;
  logic [LOCK_CNT_W-1:0] lock_cnt;

  assign hdr_valid = (serdes_rx.hdr == SYNC_DATA) || (serdes_rx.hdr == SYNC_CTRL);

  assign word_idle.d  = {8{XGMII_IDLE}};
  assign word_idle.c  = 8'hff;
  assign word_error.d = {8{XGMII_ERROR}};
  assign word_error.c = 8'hff;

  always_comb begin
    word_next = word_error;
    bad_next  = 1'b1;
    ipg_next  = 1'b0;
    if (serdes_rx.hdr == SYNC_DATA) begin
      word_next.d = serdes_rx.payload.data;
      word_next.c = 8'h00;
      bad_next    = 1'b0;
    end else if (serdes_rx.hdr == SYNC_CTRL) begin
      case (serdes_rx.payload.ctrl.block_type)
        BT_IDLE: begin
          word_next = word_idle;
          bad_next  = 1'b0;
        end
        BT_IPG: begin
          // Side-channel chunk looks like idle to the MAC
          word_next = word_idle;
          bad_next  = 1'b0;
          ipg_next  = 1'b1;
        end
        default: begin
          // BT_ERROR and unknown types
          word_next = word_error;
          bad_next  = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge tx_clk) begin
    ipg_chunk <= serdes_rx.payload.ctrl.body;
  end

  always_ff @(posedge tx_clk) begin
    if (rst) begin
      xgmii_rx     <= word_idle;
      ipg_valid    <= 1'b0;
      rx_bad_block <= 1'b0;
    end else begin
      xgmii_rx     <= word_next;
      ipg_valid    <= ipg_next;
      rx_bad_block <= bad_next;
    end
  end

  // Lock after LOCK_COUNT good headers in a row
  always_ff @(posedge tx_clk) begin
    if (rst) begin
      lock_cnt      <= '0;
      rx_block_lock <= 1'b0;
    end else if (!hdr_valid) begin
      lock_cnt      <= '0;
      rx_block_lock <= 1'b0;
    end else begin
      if (lock_cnt != LOCK_CNT_W'(LOCK_COUNT)) begin
        lock_cnt <= lock_cnt + LOCK_CNT_W'(1);
      end
      if (lock_cnt >= LOCK_CNT_W'(LOCK_COUNT - 1)) begin
        rx_block_lock <= 1'b1;
      end
    end
  end

endmodule

// File: ipg_tx_encoder.sv
// 64b/66b transmit encoder with side channel
`timescale 1ns/100ps

module ipg_tx_encoder (
  input  logic                   tx_clk,
  input  logic                   rst,
  input  phy_pkg::xgmii_word_t   xgmii_tx,
  input  logic                   head_valid,
  input  phy_pkg::ipg_chunk_t    head_chunk,
  output logic                   pop,
  output phy_pkg::serdes_block_t serdes_tx
);
  import phy_pkg::*;

  logic          is_data;
  logic          is_idle;
  serdes_block_t blk_next;
  serdes_block_t blk_idle;

  // Word classification
  assign is_data = (xgmii_tx.c == 8'h00);
  assign is_idle = (xgmii_tx.c == 8'hff) && (xgmii_tx.d == {8{XGMII_IDLE}});

  // Take the queue head only in an idle slot
  assign pop = is_idle && head_valid;

  always_comb begin
    blk_idle                          = '0;
    blk_idle.hdr                      = SYNC_CTRL;
    blk_idle.payload.ctrl.block_type  = BT_IDLE;
    blk_idle.payload.ctrl.body        = '0;
  end

  always_comb begin
    blk_next = '0;
    if (is_data) begin
      blk_next.hdr          = SYNC_DATA;
      blk_next.payload.data = xgmii_tx.d;
    end else if (is_idle) begin
      blk_next.hdr = SYNC_CTRL;
      if (head_valid) begin
        // Chunk rides in place of the idle block
        blk_next.payload.ctrl.block_type = BT_IPG;
        blk_next.payload.ctrl.body       = head_chunk;
      end else begin
        blk_next.payload.ctrl.block_type = BT_IDLE;
        blk_next.payload.ctrl.body       = '0;
      end
    end else begin
      // Mixed or unsupported control word
      blk_next.hdr                     = SYNC_CTRL;
      blk_next.payload.ctrl.block_type = BT_ERROR;
      blk_next.payload.ctrl.body       = '0;
    end
  end

  always_ff @(posedge tx_clk) begin
    if (rst) begin
      serdes_tx <= blk_idle;
    end else begin
      serdes_tx <= blk_next;
    end
  end

endmodule

// File: list.f
phy_pkg.sv
ipg_req_queue.sv
ipg_tx_encoder.sv
ipg_rx_decoder.sv
eth_ipg_phy.sv
eth_ipg_phy_assert.sv
tb_eth_ipg_phy.sv

// File: phy_pkg.sv
// PHY block format definitions
package phy_pkg;

  // XGMII word, one control flag per byte
  typedef struct packed {
    logic [63:0] d;
    logic [7:0]  c;
  } xgmii_word_t;

  typedef struct packed {
    logic [7:0]  block_type;
    logic [55:0] body;
  } ctrl_block_t;

  // Meaning of the payload depends on the sync header
  typedef union packed {
    logic [63:0] data;
    ctrl_block_t ctrl;
  } block_payload_t;

  typedef struct packed {
    logic [1:0]     hdr;
    block_payload_t payload;
  } serdes_block_t;

  typedef logic [55:0] ipg_chunk_t;

  // Producer side of the side-channel handshake
  typedef struct packed {
    logic       req;
    ipg_chunk_t chunk;
  } ipg_req_t;

  // Sync headers
  localparam logic [1:0] SYNC_DATA = 2'b10;
  localparam logic [1:0] SYNC_CTRL = 2'b01;

  // Control block types
  localparam logic [7:0] BT_IDLE  = 8'h1e;
  localparam logic [7:0] BT_IPG   = 8'ha5;
  localparam logic [7:0] BT_ERROR = 8'hfe;

  // XGMII control characters
  localparam logic [7:0] XGMII_IDLE  = 8'h07;
  localparam logic [7:0] XGMII_ERROR = 8'hfe;

  // Block lock
  localparam int LOCK_COUNT = 16;
  localparam int LOCK_CNT_W = $clog2(LOCK_COUNT + 1);

endpackage

// File: tb_eth_ipg_phy.sv
// PHY loopback testbench
`timescale 1ns/100ps

module tb_eth_ipg_phy;
  import phy_pkg::*;

  logic          tx_clk = 1'b0;
  logic          rst;
  xgmii_word_t   xgmii_tx;
  xgmii_word_t   xgmii_rx;
  serdes_block_t serdes_tx;
  serdes_block_t serdes_rx;
  ipg_req_t      ipg_req;
  logic          ipg_ack;
  ipg_chunk_t    ipg_chunk;
  logic          ipg_valid;
  logic          rx_bad_block;
  logic          rx_block_lock;
  logic          force_bad_hdr;

  xgmii_word_t   exp_d1;
  xgmii_word_t   exp_d2;
  xgmii_word_t   tx_q;
  serdes_block_t blk_exp;
  logic          exp_lock;
  int            good_run;
  logic          ack_q;
  ipg_chunk_t    exp_chunks[$];
  ipg_chunk_t    chunk_exp;
  int            errors = 0;
  int            mon_errors = 0;
  string         test_name = "reset";

  always #50 tx_clk = ~tx_clk;

  // Serial loopback with the header forced to 00 on request
  assign serdes_rx = force_bad_hdr ? {2'b00, serdes_tx.payload} : serdes_tx;

  eth_ipg_phy i_eth_ipg_phy (
    .tx_clk        (tx_clk),
    .rst           (rst),
    .xgmii_tx      (xgmii_tx),
    .xgmii_rx      (xgmii_rx),
    .serdes_tx     (serdes_tx),
    .serdes_rx     (serdes_rx),
    .ipg_req       (ipg_req),
    .ipg_ack       (ipg_ack),
    .ipg_chunk     (ipg_chunk),
    .ipg_valid     (ipg_valid),
    .rx_bad_block  (rx_bad_block),
    .rx_block_lock (rx_block_lock)
  );

  function automatic xgmii_word_t idle_word();
    xgmii_word_t w;
    w.d = {8{XGMII_IDLE}};
    w.c = 8'hff;
    return w;
  endfunction

  function automatic xgmii_word_t error_word();
    xgmii_word_t w;
    w.d = {8{XGMII_ERROR}};
    w.c = 8'hff;
    return w;
  endfunction

  // Receive word expected for one transmit word
  function automatic xgmii_word_t expected_rx(xgmii_word_t w);
    if (w.c == 8'h00) begin
      return w;
    end
    if (w.c == 8'hff && w.d == {8{XGMII_IDLE}}) begin
      return idle_word();
    end
    return error_word();
  endfunction

  // Transmit block for one word when no chunk is waiting
  function automatic serdes_block_t expected_block(xgmii_word_t w);
    serdes_block_t b;
    if (w.c == 8'h00) begin
      b = {SYNC_DATA, w.d};
    end else if (expected_rx(w) == idle_word()) begin
      b = {SYNC_CTRL, BT_IDLE, 56'h0};
    end else begin
      b = {SYNC_CTRL, BT_ERROR, 56'h0};
    end
    return b;
  endfunction

  function automatic ipg_chunk_t random_chunk();
    return 56'({$urandom, $urandom});
  endfunction

  task automatic report_mismatch(string what, logic [71:0] exp, logic [71:0] act);
    $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = i_eth_ipg_phy.i_eth_ipg_phy_assert.fail_count;
    $display("Errors: %0d step checks, %0d monitor checks, %0d assertions",
             errors, mon_errors, assert_fails);
    if (errors == 0 && mon_errors == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic timed_out(string what);
    $display("Timeout waiting for %s in test %s", what, test_name);
    errors++;
    finish_run();
  endtask

  // Pipeline, lock, block and chunk scoreboard at the rising edge
  always @(posedge tx_clk) begin
    if (rst) begin
      exp_d1   = idle_word();
      exp_d2   = idle_word();
      tx_q     = idle_word();
      exp_lock = 1'b0;
      good_run = 0;
      ack_q    = 1'b0;
      exp_chunks.delete();
    end else begin
      assert (xgmii_rx == exp_d2) else begin
        report_mismatch("xgmii_rx", exp_d2, xgmii_rx);
        mon_errors++;
      end
      assert (rx_bad_block == (exp_d2 == error_word())) else begin
        report_mismatch("rx_bad_block", 72'(exp_d2 == error_word()), 72'(rx_bad_block));
        mon_errors++;
      end
      assert (rx_block_lock == exp_lock) else begin
        report_mismatch("rx_block_lock", 72'(exp_lock), 72'(rx_block_lock));
        mon_errors++;
      end
      blk_exp = expected_block(tx_q);
      // A chunk may take the place of an idle block
      assert (serdes_tx == blk_exp ||
              (blk_exp.hdr == SYNC_CTRL &&
               blk_exp.payload.ctrl.block_type == BT_IDLE &&
               serdes_tx.hdr == SYNC_CTRL &&
               serdes_tx.payload.ctrl.block_type == BT_IPG)) else begin
        report_mismatch("serdes_tx", 72'(blk_exp), 72'(serdes_tx));
        mon_errors++;
      end
      if (ipg_valid) begin
        if (exp_chunks.size() == 0) begin
          $display("Chunk on ipg_chunk without an accepted request in test %s", test_name);
          mon_errors++;
        end else begin
          chunk_exp = exp_chunks.pop_front();
          assert (ipg_chunk == chunk_exp) else begin
            report_mismatch("ipg_chunk", 72'(chunk_exp), 72'(ipg_chunk));
            mon_errors++;
          end
        end
      end
      if (ipg_ack && !ack_q) begin
        exp_chunks.push_back(ipg_req.chunk);
      end
      ack_q  = ipg_ack;
      exp_d2 = force_bad_hdr ? error_word() : exp_d1;
      exp_d1 = expected_rx(xgmii_tx);
      tx_q   = xgmii_tx;
      if (force_bad_hdr) begin
        good_run = 0;
        exp_lock = 1'b0;
      end else begin
        if (good_run < LOCK_COUNT) begin
          good_run++;
        end
        if (good_run >= LOCK_COUNT) begin
          exp_lock = 1'b1;
        end
      end
    end
  end

  task automatic run_idle(int n);
    repeat (n) begin
      @(negedge tx_clk);
      xgmii_tx = idle_word();
    end
  endtask

  task automatic run_data(int n);
    repeat (n) begin
      @(negedge tx_clk);
      xgmii_tx.d = {$urandom, $urandom};
      xgmii_tx.c = 8'h00;
    end
  endtask

  task automatic wait_ack(logic level, string what);
    int cycles;
    cycles = 0;
    while (ipg_ack != level) begin
      @(negedge tx_clk);
      cycles++;
      if (cycles > 200) begin
        timed_out(what);
      end
    end
  endtask

  // Producer side of the four-phase handshake
  task automatic issue_request(ipg_chunk_t chunk);
    @(negedge tx_clk);
    wait_ack(1'b0, "ack low before a new request");
    ipg_req.req   = 1'b1;
    ipg_req.chunk = chunk;
    @(negedge tx_clk);
    wait_ack(1'b1, "ack of a request");
    ipg_req.req = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_chunks.size() != 0) begin
      @(negedge tx_clk);
      cycles++;
      if (cycles > 200) begin
        timed_out("accepted chunks on ipg_valid");
      end
    end
  endtask

  initial begin
    void'($urandom(53712));
    rst           = 1'b1;
    xgmii_tx      = idle_word();
    ipg_req       = '0;
    force_bad_hdr = 1'b0;
    repeat (5) @(negedge tx_clk);
    rst = 1'b0;
    @(negedge tx_clk);
    assert (!ipg_ack && !ipg_valid && !rx_bad_block && !rx_block_lock) else begin
      report_mismatch("status after reset", 72'(0),
                      72'({ipg_ack, ipg_valid, rx_bad_block, rx_block_lock}));
      errors++;
    end
    run_idle(LOCK_COUNT + 4);

    test_name = "data_path";
    run_data(40);
    run_idle(4);

    test_name = "side_channel";
    fork
      repeat (4) issue_request(random_chunk());
      run_idle(60);
    join
    wait_drained();

    test_name = "back_pressure";
    fork
      repeat (3) issue_request(random_chunk());
      begin
        run_data(30);
        @(posedge tx_clk);
        assert (!ipg_ack && ipg_req.req) else begin
          $display("Third request was not held off while the queue was full");
          errors++;
        end
        run_idle(30);
      end
    join
    wait_drained();

    test_name = "error_word";
    @(negedge tx_clk);
    xgmii_tx.d = {$urandom, $urandom};
    xgmii_tx.c = 8'h0f;
    run_idle(6);

    test_name = "header_corruption";
    @(negedge tx_clk);
    force_bad_hdr = 1'b1;
    @(negedge tx_clk);
    force_bad_hdr = 1'b0;
    run_idle(LOCK_COUNT + 4);
    finish_run();
  end

endmodule
